// File: fetch_unit.f
+incdir+src
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/line_fill.sv
src/fetch_line_buffer.sv
src/fetch_queue.sv
src/fetch_unit.sv
dv/bmem_model.sv
dv/fetch_unit_tb.sv

// File: Makefile
TOP := fetch_unit_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f fetch_unit.f \
		--top-module $(TOP) -Mdir $(OBJ) -o V$(TOP)

run: compile
	./$(OBJ)/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then \
		echo "run failed, see sim.log"; \
		exit 1; \
	fi
	@grep -q "SIMULATION PASSED" sim.log || (echo "run ended early"; exit 1)

clean:
	rm -rf $(OBJ) sim.log

// File: dv/fetch_unit_tb.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_unit_tb;

    import fetch_pkg::*;

    localparam logic [31:0] word_pattern = 32'h5A3C_96E1;
    localparam int          wait_limit   = 4000;  // cycles per entry
    localparam int          num_rows     = 7;

    typedef struct packed {
        logic  redirect;
        addr_t target;
        int    stall;
        int    deqs;
        addr_t first_pc;
    } row_t;

    logic  clk;
    logic  rst;
    addr_t bmem_addr;
    logic  bmem_read;
    logic  bmem_ready;
    beat_t bmem_rdata;
    logic  bmem_rvalid;
    logic  redirect;
    addr_t redirect_pc;
    logic  deq;
    inst_t inst;
    addr_t inst_pc;
    logic  empty;

    row_t rows [num_rows];
    int   errors     = 0;
    int   checks     = 0;
    int   read_count = 0;
    logic timed_out  = 1'b0;

    fetch_unit i_dut (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .deq_i         (deq),
        .inst_o        (inst),
        .inst_pc_o     (inst_pc),
        .empty_o       (empty)
    );

    bmem_model #(.pattern(word_pattern)) i_bmem (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_i   (bmem_addr),
        .bmem_read_i   (bmem_read),
        .bmem_ready_o  (bmem_ready),
        .bmem_rdata_o  (bmem_rdata),
        .bmem_rvalid_o (bmem_rvalid)
    );

    always #50 clk = ~clk;

    function automatic inst_t expected_word(addr_t pc);
        return pc ^ word_pattern;
    endfunction

    // redirect, idle cycles, pops, first pc expected
    task automatic load_rows();
        rows[0] = '{1'b0, 32'h0, 0, 12, `FETCH_RESET_PC};
        rows[1] = '{1'b0, 32'h0, 200, 24, 32'h1ECEB030};  // queue fills while stalled
        rows[2] = '{1'b1, 32'h00001000, 0, 5, 32'h00001000};
        rows[3] = '{1'b0, 32'h0, 200, 1, 32'h00001014};
        rows[4] = '{1'b1, 32'h00001048, 0, 10, 32'h00001048};  // inside the held line
        rows[5] = '{1'b1, 32'h2ECEB01C, 0, 20, 32'h2ECEB01C};
        rows[6] = '{1'b1, `FETCH_RESET_PC, 30, 9, `FETCH_RESET_PC};
    endtask

    // head is sampled mid-cycle, then popped with a one-cycle deq pulse
    task automatic pop_entry(output addr_t pc, output inst_t word, output logic ok);
        int waited;
        waited = 0;
        ok     = 1'b0;
        pc     = '0;
        word   = '0;
        @(negedge clk);
        while (empty && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!empty) begin
            pc   = inst_pc;
            word = inst;
            ok   = 1'b1;
            @(posedge clk);
            deq <= 1'b1;
            @(posedge clk);
            deq <= 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && bmem_read) begin
            read_count++;
            assert (bmem_addr[4:0] == 5'd0) else begin
                $display("Fail bmem_addr_o: got %h, expected %h", bmem_addr,
                         bmem_addr & ~32'h1F);
                errors++;
            end
            assert (bmem_ready) else begin
                $display("read pulse issued while memory was not ready");
                errors++;
            end
        end
    end

    initial begin
        row_t  row;
        addr_t exp_pc;
        addr_t pc;
        inst_t word;
        logic  ok;
        int    row_errors;
        int    pops;
        void'($urandom(36819));
        clk         = 1'b0;
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        deq         = 1'b0;
        load_rows();
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < num_rows && !timed_out; r++) begin
            row        = rows[r];
            row_errors = errors;
            pops       = 0;
            if (row.redirect) begin
                @(posedge clk);
                redirect    <= 1'b1;
                redirect_pc <= row.target;
                @(posedge clk);
                redirect <= 1'b0;
            end
            repeat (row.stall) @(posedge clk);
            exp_pc = row.first_pc;
            while (pops < row.deqs && !timed_out) begin
                pop_entry(pc, word, ok);
                if (!ok) begin
                    $display("timed out waiting for a fetched entry in test %0d", r);
                    timed_out = 1'b1;
                    errors++;
                end else begin
                    checks += 2;
                    assert (pc == exp_pc) else begin
                        $display("Fail inst_pc_o: got %h, expected %h", pc, exp_pc);
                        errors++;
                    end
                    assert (word == expected_word(pc)) else begin
                        $display("Fail inst_o: got %h, expected %h", word, expected_word(pc));
                        errors++;
                    end
                    exp_pc = pc + 32'd4;
                    pops++;
                end
            end
            $display("test %0d: %0d entries, %0d errors", r, pops, errors - row_errors);
        end

        checks++;
        assert (read_count >= 6) else begin
            $display("fewer line fills than the fetched range needs");
            errors++;
        end
        $display("%0d tests, %0d checks, %0d line fills, %0d errors",
                 num_rows, checks, read_count, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : fetch_unit_tb

// File: dv/bmem_model.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module bmem_model #(
    parameter logic [31:0] pattern = 32'h0
) (
    input  logic             clk,
    input  logic             rst,

    input  fetch_pkg::addr_t bmem_addr_i,
    input  logic             bmem_read_i,

    output logic             bmem_ready_o,
    output fetch_pkg::beat_t bmem_rdata_o,
    output logic             bmem_rvalid_o
);

    import fetch_pkg::*;

    logic  ready_q = 1'b0;
    logic  valid_q = 1'b0;
    beat_t data_q  = '0;
    logic  busy_q  = 1'b0;
    addr_t base_q  = '0;
    int    beat_q  = 0;
    int    gap_q   = 0;

    assign bmem_ready_o  = ready_q;
    assign bmem_rvalid_o = valid_q;
    assign bmem_rdata_o  = data_q;

    // every word holds its own address xor the pattern
    function automatic beat_t beat_at(addr_t a);
        return {(a + 32'd4) ^ pattern, a ^ pattern};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            ready_q <= 1'b0;
            valid_q <= 1'b0;
            busy_q  <= 1'b0;
            beat_q  <= 0;
            gap_q   <= 0;
        end else begin
            valid_q <= 1'b0;
            if (!busy_q) begin
                ready_q <= ($urandom % 4) != 0;  // not ready about a quarter of the time
                if (bmem_read_i) begin
                    busy_q  <= 1'b1;
                    ready_q <= 1'b0;
                    base_q  <= bmem_addr_i;
                    beat_q  <= 0;
                    gap_q   <= $urandom % 5;  // first beat latency
                end
            end else if (gap_q != 0) begin
                gap_q <= gap_q - 1;
            end else begin
                valid_q <= 1'b1;
                data_q  <= beat_at(base_q + addr_t'(beat_q * 8));
                gap_q   <= $urandom % 4;
                if (beat_q == `FETCH_LINE_BEATS - 1) begin
                    busy_q <= 1'b0;
                end else begin
                    beat_q <= beat_q + 1;
                end
            end
        end
    end

endmodule : bmem_model

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic             clk,
    input  logic             rst,

    // burst memory
    output fetch_pkg::addr_t bmem_addr_o,
    output logic             bmem_read_o,
    input  logic             bmem_ready_i,
    input  fetch_pkg::beat_t bmem_rdata_i,
    input  logic             bmem_rvalid_i,

    // from the branch unit
    input  logic             redirect_i,
    input  fetch_pkg::addr_t redirect_pc_i,

    // to decode
    input  logic             deq_i,
    output fetch_pkg::inst_t inst_o,
    output fetch_pkg::addr_t inst_pc_o,
    output logic             empty_o
);

    import fetch_pkg::*;

    addr_t pc;
    logic  enq;
    logic  flush;
    logic  fill_start;
    logic  hit;
    inst_t hit_word;
    logic  fill_busy;
    logic  fill_done;
    line_t fill_line;
    addr_t fill_addr;
    logic  queue_full;

    fetch_pc_gen i_pc_gen (
        .clk           (clk),
        .rst           (rst),
        .hit_i         (hit),
        .full_i        (queue_full),
        .fill_busy_i   (fill_busy),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .pc_o          (pc),
        .enq_o         (enq),
        .flush_o       (flush),
        .fill_start_o  (fill_start)
    );

    line_fill i_line_fill (
        .clk           (clk),
        .rst           (rst),
        .fill_start_i  (fill_start),
        .fill_pc_i     (pc),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .fill_busy_o   (fill_busy),
        .fill_done_o   (fill_done),
        .fill_line_o   (fill_line),
        .fill_addr_o   (fill_addr)
    );

    fetch_line_buffer i_line_buffer (
        .clk         (clk),
        .rst         (rst),
        .pc_i        (pc),
        .fill_done_i (fill_done),
        .fill_line_i (fill_line),
        .fill_addr_i (fill_addr),
        .hit_o       (hit),
        .hit_word_o  (hit_word)
    );

    fetch_queue #(.payload_t(inst_t)) i_inst_queue (
        .clk     (clk),
        .rst     (rst),
        .wdata_i (hit_word),
        .enq_i   (enq),
        .deq_i   (deq_i),
        .flush_i (flush),
        .rdata_o (inst_o),
        .full_o  (queue_full),
        .empty_o (empty_o)
    );

    // same strobes as the word queue, so its flags are redundant
    fetch_queue #(.payload_t(addr_t)) i_pc_queue (
        .clk     (clk),
        .rst     (rst),
        .wdata_i (pc),
        .enq_i   (enq),
        .deq_i   (deq_i),
        .flush_i (flush),
        .rdata_o (inst_pc_o),
        .full_o  (),
        .empty_o ()
    );

endmodule : fetch_unit

// File: src/fetch_queue.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_queue #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,

    input  payload_t wdata_i,
    input  logic     enq_i,
    input  logic     deq_i,
    input  logic     flush_i,

    output payload_t rdata_o,
    output logic     full_o,
    output logic     empty_o
);

    localparam int unsigned depth     = `FETCH_QUEUE_DEPTH;
    localparam int unsigned ptr_bits  = $clog2(depth);
    localparam int unsigned cnt_bits  = $clog2(depth + 1);

    payload_t            mem_q [depth];
    logic [ptr_bits-1:0] wr_ptr_q;
    logic [ptr_bits-1:0] rd_ptr_q;
    logic [cnt_bits-1:0] count_q;
    logic                do_enq;
    logic                do_deq;

    assign full_o  = (count_q == cnt_bits'(depth));
    assign empty_o = (count_q == '0);
    assign rdata_o = mem_q[rd_ptr_q];

    assign do_enq = enq_i && !full_o && !flush_i;
    assign do_deq = deq_i && !empty_o && !flush_i;  // pop on empty is dropped

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
            end
            if (do_deq) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem_q[wr_ptr_q] <= wdata_i;
        end
    end

    // the pc side must hold while this queue is full
    assert property (@(posedge clk) disable iff (rst)
        !(enq_i && full_o))
        else $error("enqueue while full");

endmodule : fetch_queue

// File: src/fetch_line_buffer.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_line_buffer (
    input  logic             clk,
    input  logic             rst,

    input  fetch_pkg::addr_t pc_i,

    input  logic             fill_done_i,
    input  fetch_pkg::line_t fill_line_i,
    input  fetch_pkg::addr_t fill_addr_i,

    output logic             hit_o,
    output fetch_pkg::inst_t hit_word_o
);

    import fetch_pkg::*;

    localparam int unsigned offset_bits = $clog2(`FETCH_LINE_WIDTH / 8);
    localparam addr_t       line_mask   = ~addr_t'(`FETCH_LINE_WIDTH / 8 - 1);

    logic      valid_q;
    addr_t     tag_q;
    line_t     line_q;
    addr_t     pc_tag;
    word_idx_t word_idx;

    assign pc_tag   = pc_i & line_mask;
    assign word_idx = pc_i[offset_bits-1:2];  // word within the line

    assign hit_o      = valid_q && (tag_q == pc_tag);
    assign hit_word_o = line_q[word_idx * 32 +: 32];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (fill_done_i) begin
            valid_q <= 1'b1;
        end
    end

    // new line replaces the old one whole
    always_ff @(posedge clk) begin
        if (fill_done_i) begin
            tag_q  <= fill_addr_i;
            line_q <= fill_line_i;
        end
    end

endmodule : fetch_line_buffer

// File: src/line_fill.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module line_fill (
    input  logic             clk,
    input  logic             rst,

    input  logic             fill_start_i,
    input  fetch_pkg::addr_t fill_pc_i,

    input  logic             bmem_ready_i,
    input  fetch_pkg::beat_t bmem_rdata_i,
    input  logic             bmem_rvalid_i,

    output fetch_pkg::addr_t bmem_addr_o,
    output logic             bmem_read_o,

    output logic             fill_busy_o,
    output logic             fill_done_o,
    output fetch_pkg::line_t fill_line_o,
    output fetch_pkg::addr_t fill_addr_o
);

    import fetch_pkg::*;

    localparam addr_t line_mask = ~addr_t'(`FETCH_LINE_WIDTH / 8 - 1);

    fill_state_e state_q;
    beat_idx_t   beat_q;
    addr_t       addr_q;
    line_t       line_q;
    logic        done_q;
    logic        beat_take;
    logic        last_beat;

    assign beat_take = (state_q == fill_collect) && bmem_rvalid_i;
    assign last_beat = beat_take && (beat_q == beat_idx_t'(`FETCH_LINE_BEATS - 1));

    // single pulse, only when memory can take it
    assign bmem_read_o = (state_q == fill_request) && bmem_ready_i;
    assign bmem_addr_o = addr_q;

    // stays busy through the done cycle so the pc side waits for the new line
    assign fill_busy_o = (state_q != fill_idle) || done_q;
    assign fill_done_o = done_q;
    assign fill_line_o = line_q;
    assign fill_addr_o = addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= fill_idle;
            beat_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= last_beat;
            case (state_q)
                fill_idle: begin
                    if (fill_start_i) begin
                        state_q <= fill_request;
                    end
                end
                fill_request: begin
                    if (bmem_read_o) begin
                        state_q <= fill_collect;
                        beat_q  <= '0;
                    end
                end
                fill_collect: begin
                    if (beat_take) begin
                        beat_q <= beat_q + 1'b1;
                    end
                    if (last_beat) begin
                        state_q <= fill_idle;
                    end
                end
                default: state_q <= fill_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == fill_idle) && fill_start_i) begin
            addr_q <= fill_pc_i & line_mask;  // line aligned
        end
        if (beat_take) begin
            line_q[beat_q * `FETCH_BEAT_WIDTH +: `FETCH_BEAT_WIDTH] <= bmem_rdata_i;
        end
    end

    // memory only returns beats for a burst we asked for
    assert property (@(posedge clk) disable iff (rst)
        !(bmem_rvalid_i && (state_q == fill_idle)))
        else $error("beat returned with no fill in flight");

endmodule : line_fill

// File: src/fetch_pc_gen.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_pc_gen (
    input  logic             clk,
    input  logic             rst,

    input  logic             hit_i,
    input  logic             full_i,
    input  logic             fill_busy_i,

    input  logic             redirect_i,
    input  fetch_pkg::addr_t redirect_pc_i,

    output fetch_pkg::addr_t pc_o,
    output logic             enq_o,
    output logic             flush_o,
    output logic             fill_start_o
);

    import fetch_pkg::*;

    addr_t pc_next;
    logic  advance;

    // word available and room in the queues
    assign advance = hit_i && !full_i && !redirect_i;

    assign enq_o   = advance;
    assign flush_o = redirect_i;  // drop everything fetched on the old path

    // miss with no fill in flight; a redirect moves the pc first
    assign fill_start_o = !hit_i && !fill_busy_i && !redirect_i;

    // redirect wins over advance, otherwise hold
    always_comb begin
        pc_next = pc_o;
        if (redirect_i) begin
            pc_next = redirect_pc_i;
        end else if (advance) begin
            pc_next = pc_o + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_o <= `FETCH_RESET_PC;
        end else begin
            pc_o <= pc_next;
        end
    end

    // the sequencer takes every fill request and is busy the next cycle
    assert property (@(posedge clk) disable iff (rst)
        fill_start_o |=> fill_busy_i)
        else $error("fill request not taken by the line fill sequencer");

endmodule : fetch_pc_gen

// File: src/fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

    typedef logic [31:0] addr_t;  // byte address
    typedef logic [31:0] inst_t;  // rv32i instruction word

    typedef logic [`FETCH_BEAT_WIDTH-1:0] beat_t;
    typedef logic [`FETCH_LINE_WIDTH-1:0] line_t;

    // beat counter during a burst
    typedef logic [$clog2(`FETCH_LINE_BEATS)-1:0] beat_idx_t;

    // word select inside a line
    typedef logic [$clog2(`FETCH_WORDS_PER_LINE)-1:0] word_idx_t;

    // line fill sequencer
    typedef enum logic [1:0] {
        fill_idle,
        fill_request,
        fill_collect
    } fill_state_e;

endpackage : fetch_pkg

// File: src/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// first fetch address out of reset
`define FETCH_RESET_PC 32'h1ECEB000

// burst memory geometry
`define FETCH_BEAT_WIDTH 64
`define FETCH_LINE_BEATS 4

// one line is four beats
`define FETCH_LINE_WIDTH 256
`define FETCH_WORDS_PER_LINE 8

// entries in each fetch queue
`define FETCH_QUEUE_DEPTH 16

`endif
